// File: hw/sound_pkg.sv
// shared widths, port offsets, dsp commands and fm register indices for the sound block
// modules import it inside their body and use scoped names in their port lists
package sound_pkg;

    typedef logic [7:0]         byte_t;     // register / bus byte
    typedef logic signed [15:0] sample_t;   // signed audio sample
    typedef logic [12:0]        period_t;   // clk cycles in one 80us tick
    typedef logic [3:0]         io_addr_t;  // offset in 220h window
    typedef logic [1:0]         fm_addr_t;  // offset in 388h window

    typedef enum logic [2:0] {
        IDLE, WAIT_ARG, DAC, TC, LEN_LO, LEN_HI, PLAY, VERSION
    } dsp_state_t;

    // --------------------------------------------------
    // dsp
    localparam io_addr_t DSP_RESET_OFS = 4'd6;
    localparam io_addr_t DSP_READ_OFS  = 4'd10;
    localparam io_addr_t DSP_WRITE_OFS = 4'd12;   // command in, busy flag out
    localparam io_addr_t DSP_AVAIL_OFS = 4'd14;   // data ready, irq ack

    localparam byte_t CMD_DAC     = 8'h10;
    localparam byte_t CMD_DMA8    = 8'h14;
    localparam byte_t CMD_TC      = 8'h40;
    localparam byte_t CMD_SPK_ON  = 8'hD1;
    localparam byte_t CMD_SPK_OFF = 8'hD3;
    localparam byte_t CMD_VERSION = 8'hE1;

    localparam byte_t DSP_RESET_ACK = 8'hAA;
    localparam byte_t DSP_VER_MAJOR = 8'h04;
    localparam byte_t DSP_VER_MINOR = 8'h05;
    localparam int    TC_UNIT       = 4;          // clk cycles per time constant step

    // --------------------------------------------------
    // fm
    localparam byte_t   FM_REG_T1         = 8'h02;
    localparam byte_t   FM_REG_TCTRL      = 8'h04;
    localparam byte_t   FM_REG_FLO        = 8'hA0;
    localparam byte_t   FM_REG_KEY        = 8'hB0;   // key-on bit 5, freq hi bits 1:0
    localparam sample_t FM_AMP            = 16'sh4000;
    localparam int      FM_TICK_DIV       = 64;      // clk cycles per phase step
    localparam int      FM_DIV_W          = $clog2(FM_TICK_DIV);
    localparam period_t PERIOD_80US_RESET = 13'd2400;
    localparam logic [8:0] MGMT_PERIOD_ADDR = 9'd256;

endpackage

// File: hw/io_bus_if.sv
// byte wide register bus between the address decoder and the dsp / fm targets
// reads are combinational, a write is a one cycle strobe
`timescale 1ns/1ps

interface io_bus_if;
    import sound_pkg::*;

    io_addr_t address;     // fm bus uses low 2 bits
    logic     read;
    logic     write;
    byte_t    writedata;
    byte_t    readdata;

    modport host (
        output address, read, write, writedata,
        input  readdata
    );

    modport target (
        input  address, read, write, writedata,
        output readdata
    );
endinterface

// File: hw/sound_io_decode.sv
// splits the 220h and 388h host windows onto the dsp and fm buses, merges read data
// and holds the management programmed 80us tick length
`timescale 1ns/1ps

module sound_io_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  sound_pkg::io_addr_t io_address,
    input  logic                io_read,
    input  logic                io_write,
    input  sound_pkg::byte_t    io_writedata,
    output sound_pkg::byte_t    io_readdata,
    input  sound_pkg::fm_addr_t fm_address,
    input  logic                fm_read,
    input  logic                fm_write,
    input  sound_pkg::byte_t    fm_writedata,
    output sound_pkg::byte_t    fm_readdata,
    input  logic [8:0]          mgmt_address,
    input  logic                mgmt_write,
    input  logic [31:0]         mgmt_writedata,
    output sound_pkg::period_t  period_80us,
    io_bus_if.host              dsp_bus,
    io_bus_if.host              fm_bus
);
    import sound_pkg::*;

    logic io_fm_hit;   // 228h/229h alias the fm index/data pair
    logic io_to_fm;    // 220h window owns the fm bus this cycle

    assign io_fm_hit = (io_address[3:1] == 3'b100);
    assign io_to_fm  = io_fm_hit && (io_read || io_write);

    assign dsp_bus.address   = io_address;
    assign dsp_bus.read      = io_read && !io_fm_hit;
    assign dsp_bus.write     = io_write && !io_fm_hit;
    assign dsp_bus.writedata = io_writedata;

    assign fm_bus.address   = io_to_fm ? {2'b00, io_address[1:0]} : {2'b00, fm_address};
    assign fm_bus.read      = (io_read && io_fm_hit) || fm_read;
    assign fm_bus.write     = (io_write && io_fm_hit) || fm_write;
    assign fm_bus.writedata = io_to_fm ? io_writedata : fm_writedata;

    // fm target returns status at offset 0, ffh at the others
    assign io_readdata = io_fm_hit ? fm_bus.readdata : dsp_bus.readdata;
    assign fm_readdata = fm_bus.readdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_80us <= PERIOD_80US_RESET;
        end else if (mgmt_write && mgmt_address == MGMT_PERIOD_ADDR) begin
            period_80us <= mgmt_writedata[12:0];    // upper bits ignored
        end
    end

endmodule

// File: hw/sound_dsp.sv
// sound blaster dsp: command parser, reply queue, direct dac and 8-bit single cycle
// dma playback paced by the time constant; block end raises irq until 22Eh is read
`timescale 1ns/1ps

module sound_dsp (
    input  logic             clk,
    input  logic             rst_n,
    io_bus_if.target         bus,
    input  logic             dma_ack,
    input  logic             dma_terminal,   // block length decides the end, not this
    input  sound_pkg::byte_t dma_readdata,
    output logic             irq,
    output logic             dma_req,
    output logic             dsp_sample_do,
    output sound_pkg::byte_t dsp_sample_value,
    output logic             dsp_speaker_off
);
    import sound_pkg::*;

    dsp_state_t  state;
    byte_t       cmd;           // command waiting for its argument
    byte_t       tc;            // time constant
    byte_t       len_lo;
    byte_t       q_data [2];    // reply queue, head at 0
    logic [1:0]  q_count;
    logic        reset_bit;     // last value written to 226h
    logic [10:0] rate_period;   // cycles per sample
    logic [10:0] rate_cnt;
    logic [15:0] len_cnt;       // bytes left minus one
    logic        have_byte;     // fetched byte waiting for period end

    logic wr_reset;
    logic wr_cmd;
    logic rd_data;
    logic rd_avail;
    logic soft_reset;
    logic period_end;

    assign wr_reset   = bus.write && bus.address == DSP_RESET_OFS;
    assign wr_cmd     = bus.write && bus.address == DSP_WRITE_OFS;
    assign rd_data    = bus.read && bus.address == DSP_READ_OFS;
    assign rd_avail   = bus.read && bus.address == DSP_AVAIL_OFS;
    assign soft_reset = wr_reset && reset_bit && !bus.writedata[0];   // 1 then 0
    assign period_end = state == PLAY && rate_cnt == '0 && have_byte;

    assign dsp_sample_do = (state == DAC) || period_end;

    always_comb begin
        case (bus.address)
            DSP_READ_OFS:  bus.readdata = q_data[0];
            DSP_WRITE_OFS: bus.readdata = {state != IDLE, 7'h7F};    // busy
            DSP_AVAIL_OFS: bus.readdata = {q_count != 2'd0, 7'h7F};  // data ready
            default:       bus.readdata = 8'hFF;
        endcase
    end

    // --------------------------------------------------
    // command machine and dma pacing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= IDLE;
            reset_bit       <= 1'b0;
            q_count         <= 2'd0;
            irq             <= 1'b0;
            dma_req         <= 1'b0;
            have_byte       <= 1'b0;
            dsp_speaker_off <= 1'b0;
            rate_period     <= 11'd1024;   // tc of 0
            rate_cnt        <= '0;
            len_cnt         <= '0;
        end else begin
            if (wr_reset) reset_bit <= bus.writedata[0];
            if (rd_avail) irq <= 1'b0;                  // irq ack

            if (state == VERSION)             q_count <= 2'd2;
            else if (soft_reset)              q_count <= 2'd1;
            else if (rd_data && q_count != 0) q_count <= q_count - 2'd1;

            if (soft_reset) begin
                state     <= IDLE;                      // abort any block
                irq       <= 1'b0;
                dma_req   <= 1'b0;
                have_byte <= 1'b0;
            end else begin
                case (state)
                    IDLE: if (wr_cmd) begin
                        case (bus.writedata)
                            CMD_DAC, CMD_TC: state <= WAIT_ARG;
                            CMD_DMA8:        state <= LEN_LO;
                            CMD_VERSION:     state <= VERSION;
                            CMD_SPK_ON:      dsp_speaker_off <= 1'b0;
                            CMD_SPK_OFF:     dsp_speaker_off <= 1'b1;
                            default: ;                  // unsupported, dropped
                        endcase
                    end
                    WAIT_ARG: if (wr_cmd) state <= (cmd == CMD_DAC) ? DAC : TC;
                    DAC: state <= IDLE;                 // strobe cycle
                    TC: begin
                        rate_period <= 11'((11'd256 - 11'(tc)) * TC_UNIT);
                        state       <= IDLE;
                    end
                    LEN_LO: if (wr_cmd) state <= LEN_HI;
                    LEN_HI: if (wr_cmd) begin
                        len_cnt  <= {bus.writedata, len_lo};
                        rate_cnt <= rate_period - 11'd1;
                        dma_req  <= 1'b1;               // first fetch
                        state    <= PLAY;
                    end
                    PLAY: begin
                        if (dma_req && dma_ack) begin
                            dma_req   <= 1'b0;          // byte captured
                            have_byte <= 1'b1;
                        end else if (!dma_req && !have_byte && !dma_ack) begin
                            dma_req <= 1'b1;            // ack low, period done
                        end
                        if (rate_cnt != '0) begin
                            rate_cnt <= rate_cnt - 11'd1;
                        end else if (have_byte) begin   // late byte stretches period
                            have_byte <= 1'b0;
                            rate_cnt  <= rate_period - 11'd1;
                            if (len_cnt == '0) begin
                                irq   <= 1'b1;          // last byte out
                                state <= IDLE;
                            end else begin
                                len_cnt <= len_cnt - 16'd1;
                            end
                        end
                    end
                    default: state <= IDLE;             // VERSION fills queue
                endcase
            end
        end
    end

    // --------------------------------------------------
    // argument and sample bytes, reply queue contents
    always_ff @(posedge clk) begin
        if (state == IDLE && wr_cmd) cmd <= bus.writedata;
        if (state == WAIT_ARG && wr_cmd) begin
            if (cmd == CMD_DAC) dsp_sample_value <= bus.writedata;
            else                tc <= bus.writedata;
        end
        if (state == LEN_LO && wr_cmd)            len_lo <= bus.writedata;
        if (state == PLAY && dma_req && dma_ack)  dsp_sample_value <= dma_readdata;

        if (state == VERSION) begin
            q_data[0] <= DSP_VER_MAJOR;
            q_data[1] <= DSP_VER_MINOR;
        end else if (soft_reset) begin
            q_data[0] <= DSP_RESET_ACK;
        end else if (rd_data) begin
            q_data[0] <= q_data[1];                     // pop
        end
    end

endmodule

// File: hw/fm_tone.sv
// reduced fm block: index/data register pair, timer 1 with status flags and one
// square wave tone voice stepped every FM_TICK_DIV clocks
`timescale 1ns/1ps

module fm_tone (
    input  logic               clk,
    input  logic               rst_n,
    io_bus_if.target           bus,
    input  sound_pkg::period_t period_80us,
    output sound_pkg::sample_t fm_sample
);
    import sound_pkg::*;

    byte_t               index;      // selected register
    byte_t               t1_load;    // timer 1 reload value
    byte_t               t1_cnt;
    logic                t1_run;
    logic                st_irq;     // status bit 7
    logic                st_t1;      // status bit 6
    period_t             tick_cnt;   // clk cycles into current 80us tick
    logic [9:0]          freq;
    logic                key_on;
    logic [15:0]         phase;
    logic [FM_DIV_W-1:0] div_cnt;
    logic                data_wr;
    logic                tctrl_wr;

    assign data_wr  = bus.write && bus.address[0];
    assign tctrl_wr = data_wr && index == FM_REG_TCTRL;

    assign bus.readdata = (bus.read && bus.address[1:0] == 2'd0) ?
                          {st_irq, st_t1, 6'd0} : 8'hFF;

    // --------------------------------------------------
    // register file
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index   <= '0;
            t1_load <= '0;
            freq    <= '0;
            key_on  <= 1'b0;
        end else begin
            if (bus.write && !bus.address[0]) index <= bus.writedata;
            if (data_wr) begin
                case (index)
                    FM_REG_T1:  t1_load <= bus.writedata;
                    FM_REG_FLO: freq[7:0] <= bus.writedata;
                    FM_REG_KEY: begin
                        freq[9:8] <= bus.writedata[1:0];
                        key_on    <= bus.writedata[5];
                    end
                    default: ;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // timer 1, one count per 80us tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t1_run   <= 1'b0;
            t1_cnt   <= '0;
            tick_cnt <= '0;
            st_irq   <= 1'b0;
            st_t1    <= 1'b0;
        end else if (tctrl_wr && bus.writedata[7]) begin
            st_irq <= 1'b0;                             // flag reset, rest ignored
            st_t1  <= 1'b0;
        end else if (tctrl_wr) begin
            t1_run   <= bus.writedata[0];
            t1_cnt   <= t1_load;
            tick_cnt <= '0;
        end else if (t1_run) begin
            if (tick_cnt == period_80us - 13'd1) begin
                tick_cnt <= '0;
                if (t1_cnt == 8'hFF) begin
                    t1_cnt <= t1_load;                  // overflow, reload
                    st_irq <= 1'b1;
                    st_t1  <= 1'b1;
                end else begin
                    t1_cnt <= t1_cnt + 8'd1;
                end
            end else begin
                tick_cnt <= tick_cnt + 13'd1;
            end
        end
    end

    // --------------------------------------------------
    // tone voice
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            phase   <= '0;
        end else begin
            if (div_cnt == FM_DIV_W'(FM_TICK_DIV - 1)) div_cnt <= '0;
            else                                       div_cnt <= div_cnt + 1'b1;
            if (!key_on)            phase <= '0;        // restart on next key-on
            else if (div_cnt == '0) phase <= phase + {6'd0, freq};
        end
    end

    assign fm_sample = !key_on ? '0 : (phase[15] ? -FM_AMP : FM_AMP);

endmodule

// File: hw/sound_mixer.sv
// holds the dsp byte as a signed sample and sums it with the fm voice per channel
// dsp takes a quarter, fm a half of full scale
`timescale 1ns/1ps

module sound_mixer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dsp_sample_do,
    input  sound_pkg::byte_t   dsp_sample_value,
    input  logic               dsp_speaker_off,
    input  sound_pkg::sample_t fm_sample,
    output sound_pkg::sample_t sample_l,
    output sound_pkg::sample_t sample_r
);
    import sound_pkg::*;

    sample_t dsp_held;   // last dsp sample
    sample_t dsp_next;
    sample_t mix;

    always_comb begin
        dsp_next = dsp_held;
        if (dsp_speaker_off) begin
            dsp_next = '0;
        end else if (dsp_sample_do) begin
            // unsigned to signed, byte repeated into the low half
            dsp_next = {~dsp_sample_value[7], dsp_sample_value[6:0], dsp_sample_value};
        end
    end

    assign mix = (dsp_next >>> 2) + (fm_sample >>> 1);   // cannot overflow

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dsp_held <= '0;
            sample_l <= '0;
            sample_r <= '0;
        end else begin
            dsp_held <= dsp_next;
            sample_l <= mix;     // mono sources, both channels equal
            sample_r <= mix;
        end
    end

endmodule

// File: hw/sound_top.sv
// sound blaster style audio block: 220h and 388h host windows, 8-bit dma playback,
// reduced fm tone and stereo mix; management address 256 sets the 80us tick length
`timescale 1ns/1ps

module sound_top (
    input  logic                clk,
    input  logic                rst_n,
    output logic                irq,
    input  sound_pkg::io_addr_t io_address,
    input  logic                io_read,
    input  logic                io_write,
    input  sound_pkg::byte_t    io_writedata,
    output sound_pkg::byte_t    io_readdata,
    input  sound_pkg::fm_addr_t fm_address,
    input  logic                fm_read,
    input  logic                fm_write,
    input  sound_pkg::byte_t    fm_writedata,
    output sound_pkg::byte_t    fm_readdata,
    output logic                dma_req,
    input  logic                dma_ack,
    input  logic                dma_terminal,
    input  sound_pkg::byte_t    dma_readdata,
    output sound_pkg::sample_t  sample_l,
    output sound_pkg::sample_t  sample_r,
    input  logic [8:0]          mgmt_address,
    input  logic                mgmt_write,
    input  logic [31:0]         mgmt_writedata
);
    import sound_pkg::*;

    io_bus_if dsp_bus ();
    io_bus_if fm_bus ();

    period_t period_80us;
    logic    dsp_sample_do;
    byte_t   dsp_sample_value;
    logic    dsp_speaker_off;
    sample_t fm_sample;

    sound_io_decode decode_i (
        .clk, .rst_n,
        .io_address, .io_read, .io_write, .io_writedata, .io_readdata,
        .fm_address, .fm_read, .fm_write, .fm_writedata, .fm_readdata,
        .mgmt_address, .mgmt_write, .mgmt_writedata,
        .period_80us,
        .dsp_bus (dsp_bus.host),
        .fm_bus  (fm_bus.host)
    );

    sound_dsp dsp_i (
        .clk, .rst_n,
        .bus (dsp_bus.target),
        .dma_ack, .dma_terminal, .dma_readdata,
        .irq, .dma_req,
        .dsp_sample_do, .dsp_sample_value, .dsp_speaker_off
    );

    fm_tone fm_i (
        .clk, .rst_n,
        .bus (fm_bus.target),
        .period_80us,
        .fm_sample
    );

    sound_mixer mixer_i (
        .clk, .rst_n,
        .dsp_sample_do, .dsp_sample_value, .dsp_speaker_off,
        .fm_sample,
        .sample_l, .sample_r
    );

endmodule

// File: dv/sound_tb.sv
// testbench for sound_top: dsp reset/version, direct dac, dma playback, fm timer and tone
// dma bytes come from an xorshift generator, every sample change is checked against mix_ref
`timescale 1ns/1ps

module sound_tb;
    import sound_pkg::*;

    localparam int TIMEOUT_CYCLES = 60000;
    localparam int DMA_LEN        = 6;            // bytes per dma block
    localparam int T1_LIMIT       = 5 * 20 + 10;  // timer run deadline in clk cycles
    localparam int TONE_CYCLES    = 3000;         // > one tone half period at freq 3ffh

    logic     clk, rst_n, irq, io_read, io_write, fm_read, fm_write;
    logic     dma_req, dma_ack, dma_terminal, mgmt_write;
    io_addr_t io_address;
    fm_addr_t fm_address;
    byte_t    io_writedata, io_readdata, fm_writedata, fm_readdata, dma_readdata;
    logic [8:0]  mgmt_address;
    logic [31:0] mgmt_writedata;
    sample_t  sample_l, sample_r;

    logic [31:0] rng = 32'h883c_21c6;
    sample_t  exp_q[$];           // samples still to appear, in order
    sample_t  last_exp, exp_s, seen_l, seen_r;
    int       err_value, err_other, cycles, fetched, ack_delay, start;
    logic     tone_mode, pos_seen, neg_seen;
    byte_t    rd, b, dma_b;

    sound_top dut_i (.*);

    always #20 clk = ~clk;

    // --------------------------------------------------
    // helpers
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // offset binary byte repeated to 16 bits, dsp quarter plus fm half
    function automatic sample_t mix_ref(input byte_t v, input logic spk_off, input sample_t fm);
        int dsp;
        dsp = spk_off ? 0 : int'(v) * 257 - 32768;
        return sample_t'((dsp >>> 2) + (int'(fm) >>> 1));
    endfunction

    function automatic byte_t fresh_byte();   // next byte whose sample differs from the last
        do begin
            rng = xorshift(rng);
        end while (mix_ref(rng[7:0], 1'b0, 16'sd0) == last_exp);
        return rng[7:0];
    endfunction

    function automatic void expect_sample(input sample_t s);
        exp_q.push_back(s);
        last_exp = s;
    endfunction

    task automatic value_error(input string msg);
        $display("[ERROR] %0d ns %s", $time, msg);
        err_value++;
    endtask

    task automatic io_wr(input io_addr_t a, input byte_t d);
        @(negedge clk);
        io_address   = a;
        io_writedata = d;
        io_write     = 1'b1;
        @(negedge clk);
        io_write = 1'b0;
    endtask

    task automatic io_rd(input io_addr_t a, output byte_t d);
        @(negedge clk);
        io_address = a;
        io_read    = 1'b1;
        #10 d = io_readdata;        // combinational, settled well before posedge
        @(negedge clk);
        io_read = 1'b0;
    endtask

    task automatic fm_wr(input fm_addr_t a, input byte_t d);
        @(negedge clk);
        fm_address   = a;
        fm_writedata = d;
        fm_write     = 1'b1;
        @(negedge clk);
        fm_write = 1'b0;
    endtask

    task automatic fm_rd(input fm_addr_t a, output byte_t d);
        @(negedge clk);
        fm_address = a;
        fm_read    = 1'b1;
        #10 d = fm_readdata;
        @(negedge clk);
        fm_read = 1'b0;
    endtask

    task automatic tone_reg(input logic via_io, input byte_t idx, input byte_t d);
        if (via_io) begin
            io_wr(4'd8, idx);       // 228h/229h alias
            io_wr(4'd9, d);
        end else begin
            fm_wr(2'd0, idx);
            fm_wr(2'd1, d);
        end
    endtask

    task automatic wait_idle();
        byte_t st;
        do begin
            io_rd(DSP_WRITE_OFS, st);
        end while (st[7]);          // busy bit
    endtask

    task automatic dsp_cmd(input byte_t c);
        wait_idle();
        io_wr(DSP_WRITE_OFS, c);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    // --------------------------------------------------
    // dma responder, random ack delay of 0 to 7 cycles
    always begin
        @(negedge clk);
        if (rst_n && dma_req && !dma_ack) begin
            rng = xorshift(rng);
            ack_delay = int'(rng[2:0]);
            repeat (ack_delay) @(negedge clk);
            dma_b = fresh_byte();
            expect_sample(mix_ref(dma_b, 1'b0, 16'sd0));
            dma_readdata = dma_b;
            dma_ack      = 1'b1;
            fetched++;
            do @(negedge clk); while (dma_req);
            dma_ack = 1'b0;         // four phase, ack follows req down
        end
    end

    // --------------------------------------------------
    // compare process, every sample change
    always @(negedge clk) begin
        if (rst_n && (sample_l !== seen_l || sample_r !== seen_r)) begin
            if (sample_l !== sample_r) begin
                value_error($sformatf("left %h right %h", sample_l, sample_r));
            end
            if (tone_mode) begin
                if (sample_l === mix_ref(8'h00, 1'b1, FM_AMP)) pos_seen = 1'b1;
                else if (sample_l === mix_ref(8'h00, 1'b1, -FM_AMP)) neg_seen = 1'b1;
                else if (sample_l !== 16'sd0) value_error($sformatf("tone sample %h", sample_l));
            end else if (exp_q.size() == 0) begin
                value_error($sformatf("unexpected sample %h", sample_l));
            end else begin
                exp_s = exp_q.pop_front();
                if (sample_l !== exp_s) begin
                    value_error($sformatf("sample %h expected %h", sample_l, exp_s));
                end
            end
            seen_l = sample_l;
            seen_r = sample_r;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: test sequence still running after %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d value, %0d other", err_value, err_other + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    // --------------------------------------------------
    // test sequence
    initial begin
        {clk, rst_n, io_read, io_write, fm_read, fm_write, dma_ack, dma_terminal} = '0;
        {io_address, fm_address, io_writedata, fm_writedata, dma_readdata} = '0;
        {mgmt_address, mgmt_write, mgmt_writedata} = '0;
        {err_value, err_other, fetched, tone_mode} = '0;
        {last_exp, seen_l, seen_r} = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        if (irq !== 1'b0 || dma_req !== 1'b0 || sample_l !== 16'sd0)
            value_error("outputs not idle after reset");

        io_wr(DSP_RESET_OFS, 8'h01);                    // dsp reset and version
        io_wr(DSP_RESET_OFS, 8'h00);
        io_rd(DSP_AVAIL_OFS, rd);
        if (rd[7] !== 1'b1) value_error($sformatf("avail %h after dsp reset", rd));
        io_rd(DSP_READ_OFS, rd);
        if (rd !== 8'hAA) value_error($sformatf("reset ack %h", rd));
        dsp_cmd(CMD_VERSION);
        wait_idle();
        io_rd(DSP_READ_OFS, rd);
        if (rd !== 8'h04) value_error($sformatf("version major %h", rd));
        io_rd(DSP_READ_OFS, rd);
        if (rd !== 8'h05) value_error($sformatf("version minor %h", rd));

        repeat (4) begin                                // direct dac
            b = fresh_byte();
            expect_sample(mix_ref(b, 1'b0, 16'sd0));
            dsp_cmd(CMD_DAC);
            io_wr(DSP_WRITE_OFS, b);
        end
        drain();
        expect_sample(16'sd0);
        dsp_cmd(CMD_SPK_OFF);
        drain();
        dsp_cmd(CMD_SPK_ON);
        b = fresh_byte();
        expect_sample(mix_ref(b, 1'b0, 16'sd0));
        dsp_cmd(CMD_DAC);
        io_wr(DSP_WRITE_OFS, b);
        drain();

        dsp_cmd(CMD_TC);                                // dma, 64 cycle period
        io_wr(DSP_WRITE_OFS, 8'hF0);
        fetched = 0;
        dsp_cmd(CMD_DMA8);
        io_wr(DSP_WRITE_OFS, 8'(DMA_LEN - 1));
        io_wr(DSP_WRITE_OFS, 8'h00);
        while (irq !== 1'b1) @(negedge clk);
        if (fetched != DMA_LEN || exp_q.size() > 1)
            value_error($sformatf("irq with %0d of %0d bytes fetched", fetched, DMA_LEN));
        drain();
        repeat (200) @(negedge clk);
        if (fetched != DMA_LEN || dma_req !== 1'b0)
            value_error($sformatf("%0d bytes fetched after block end", fetched));
        if (irq !== 1'b1) value_error("irq dropped before 22Eh read");
        io_rd(DSP_AVAIL_OFS, rd);
        if (irq !== 1'b0) value_error("irq still high after 22Eh read");

        @(negedge clk);                                 // fm timer 1
        mgmt_address   = MGMT_PERIOD_ADDR;
        mgmt_writedata = 32'd20;
        mgmt_write     = 1'b1;
        @(negedge clk);
        mgmt_write = 1'b0;
        fm_wr(2'd0, FM_REG_T1);
        fm_wr(2'd1, 8'hFC);
        fm_wr(2'd0, FM_REG_TCTRL);
        fm_wr(2'd1, 8'h01);
        start = cycles;
        fm_rd(2'd0, rd);
        if (rd !== 8'h00) value_error($sformatf("fm status %h right after start", rd));
        while (rd !== 8'hC0 && cycles - start <= T1_LIMIT) fm_rd(2'd0, rd);
        if (rd !== 8'hC0) begin
            $display("fm timer 1 status never reached C0h within %0d cycles", T1_LIMIT);
            err_other++;
        end
        fm_wr(2'd1, 8'h80);                             // flag reset
        fm_rd(2'd0, rd);
        if (rd !== 8'h00) value_error($sformatf("fm status %h after flag reset", rd));
        fm_wr(2'd1, 8'h00);

        expect_sample(16'sd0);                          // fm tone, dsp muted
        dsp_cmd(CMD_SPK_OFF);
        drain();
        tone_mode = 1'b1;
        for (int i = 0; i < 2; i++) begin
            pos_seen = 1'b0;
            neg_seen = 1'b0;
            tone_reg(i[0], FM_REG_FLO, 8'hFF);
            tone_reg(i[0], FM_REG_KEY, 8'h23);          // key-on, freq 3ffh
            repeat (TONE_CYCLES) @(negedge clk);
            if (!pos_seen || !neg_seen) value_error($sformatf("tone pass %0d missed a level", i));
            tone_reg(i[0], FM_REG_KEY, 8'h00);
            repeat (4) @(negedge clk);
            if (sample_l !== 16'sd0 || sample_r !== 16'sd0) begin
                value_error("tone left on after key-off");
            end
        end

        $display("errors: %0d value, %0d other", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: compile.f
hw/sound_pkg.sv
hw/io_bus_if.sv
hw/sound_io_decode.sv
hw/sound_dsp.sv
hw/fm_tone.sv
hw/sound_mixer.sv
hw/sound_top.sv
dv/sound_tb.sv

// File: Makefile
# Verilator flow for the sound block testbench

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f compile.f --top-module sound_top
	verilator --lint-only --timing -f compile.f --top-module sound_tb

sim:
	verilator --binary --timing -j 0 -f compile.f --top-module sound_tb -o sound_tb
	./obj_dir/sound_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
